//--- logic/cgra_consts.svh
// cgra engine constants
`ifndef CGRA_CONSTS_SVH
`define CGRA_CONSTS_SVH

// datapath word
`define CGRA_DATA_W 16

// memory geometry
`define CGRA_MEM_DEPTH 64
`define CGRA_MEM_ADDR_W 6

// unit counts
`define CGRA_N_MEM 2
`define CGRA_N_ALU 2

// data bus slots and selector width
`define CGRA_BUS_N 8
`define CGRA_SEL_W 3

// iteration count from the configuration word
`define CGRA_ITER_W 6

// extra run cycles after the last iteration, covers write delays 0..3
`define CGRA_DRAIN 4

`endif

//--- logic/cgra_pkg.sv
// cgra engine types
`include "cgra_consts.svh"

package cgra_pkg;

   // data bus sources, also the slot index on the bus
   typedef enum logic [`CGRA_SEL_W-1:0] {
      BUS_ZERO = 3'd0,
      BUS_ONE  = 3'd1,
      BUS_IDX  = 3'd2,
      BUS_MEM0 = 3'd3,
      BUS_MEM1 = 3'd4,
      BUS_ALU0 = 3'd5,
      BUS_ALU1 = 3'd6,
      BUS_MUL0 = 3'd7
   } bus_sel_e;

   typedef enum logic [2:0] {
      ALU_ADD    = 3'd0,
      ALU_SUB    = 3'd1,
      ALU_AND    = 3'd2,
      ALU_OR     = 3'd3,
      ALU_XOR    = 3'd4,
      ALU_MAX    = 3'd5,
      ALU_PASS_A = 3'd6
   } alu_op_e;

   typedef logic [`CGRA_BUS_N-1:0][`CGRA_DATA_W-1:0] data_bus_t;

   typedef struct packed {
      logic [`CGRA_MEM_ADDR_W-1:0] rd_start;
      logic [`CGRA_MEM_ADDR_W-1:0] rd_stride;
      logic                        wr_en;
      logic [`CGRA_MEM_ADDR_W-1:0] wr_start;
      bus_sel_e                    wr_sel;
      logic [1:0]                  wr_delay;
   } mem_cfg_t;

   typedef struct packed {
      alu_op_e  op;
      bus_sel_e sel_a;
      bus_sel_e sel_b;
   } alu_cfg_t;

   typedef struct packed {
      bus_sel_e sel_a;
      bus_sel_e sel_b;
   } mul_cfg_t;

   typedef struct packed {
      logic [`CGRA_ITER_W-1:0]        iter_count;
      mem_cfg_t [`CGRA_N_MEM-1:0]     mem;
      alu_cfg_t [`CGRA_N_ALU-1:0]     alu;
      mul_cfg_t                       mul;
   } eng_cfg_t;

   typedef struct packed {
      logic                        valid;
      logic                        we;
      logic                        mem_id;
      logic [`CGRA_MEM_ADDR_W-1:0] addr;
      logic [`CGRA_DATA_W-1:0]     wdata;
   } host_req_t;

endpackage

//--- logic/cgra_ctrl_fsm.sv
// cgra run controller
`include "cgra_consts.svh"

module cgra_ctrl_fsm import cgra_pkg::*; (
   input  logic                   rst,
   input  logic                   clk,
   input  logic                   ctr_valid,
   input  logic                   ctr_we,
   input  logic                   ctr_addr,
   input  logic [`CGRA_DATA_W-1:0] ctr_data_in,
   output logic [`CGRA_DATA_W-1:0] ctr_data_out,
   input  eng_cfg_t               config_bus,
   input  logic                   last,
   output logic                   busy,
   output logic                   start,
   output eng_cfg_t               cfg
);

   typedef enum logic {
      ST_IDLE,
      ST_RUN
   } state_e;

   state_e state;
   logic   run_req;
   logic   status_rd;

   // write of bit 0 to the control register
   assign run_req = ctr_valid & ctr_we & ~ctr_addr & ctr_data_in[0];

   // strobes while busy are dropped
   assign start = run_req & (state == ST_IDLE);
   assign busy  = (state == ST_RUN);

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: if (start) state <= ST_RUN;
            ST_RUN:  if (last) state <= ST_IDLE;
            default: state <= ST_IDLE;
         endcase
      end
   end

   // shadow copy, frozen for the whole run
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         cfg <= '0;
      end else if (start) begin
         cfg <= config_bus;
      end
   end

   // status register, bit 0 high when idle
   assign status_rd = ctr_valid & ~ctr_we & ctr_addr;
   assign ctr_data_out = status_rd ? {{(`CGRA_DATA_W-1){1'b0}}, ~busy} : '0;

endmodule

//--- logic/cgra_iter_counter.sv
// cgra iteration counter
`include "cgra_consts.svh"

module cgra_iter_counter import cgra_pkg::*; (
   input  logic                    rst,
   input  logic                    clk,
   input  logic                    start,
   input  logic                    busy,
   input  logic [`CGRA_ITER_W-1:0] cfg_iter,
   output logic [`CGRA_DATA_W-1:0] idx,
   output logic                    last
);

   logic [`CGRA_DATA_W-1:0] last_idx;

   // run covers the iterations plus the drain cycles
   assign last_idx = {{(`CGRA_DATA_W-`CGRA_ITER_W){1'b0}}, cfg_iter}
                     + `CGRA_DATA_W'(`CGRA_DRAIN - 1);

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         idx <= '0;
      end else if (start) begin
         idx <= '0;
      end else if (busy) begin
         idx <= idx + 1'b1;
      end
   end

   // one pulse in the final run cycle
   assign last = busy & (idx == last_idx);

endmodule

//--- logic/cgra_mem_unit.sv
// cgra memory unit
`include "cgra_consts.svh"

module cgra_mem_unit import cgra_pkg::*; #(
   parameter int MEM_ID = 0
) (
   input  logic                    rst,
   input  logic                    clk,
   input  logic                    busy,
   input  logic [`CGRA_DATA_W-1:0] idx,
   input  mem_cfg_t                cfg,
   input  logic [`CGRA_ITER_W-1:0] iter_count,
   input  data_bus_t               bus,
   input  host_req_t               host,
   input  logic [`CGRA_DATA_W-1:0] chain_in,
   output logic [`CGRA_DATA_W-1:0] rd_word,
   output logic [`CGRA_DATA_W-1:0] chain_out
);

   logic [`CGRA_DATA_W-1:0]     mem [`CGRA_MEM_DEPTH];

   logic [`CGRA_MEM_ADDR_W-1:0] rd_off;
   logic [`CGRA_MEM_ADDR_W-1:0] rd_addr;

   logic [`CGRA_DATA_W-1:0]     wr_k;
   logic                        wr_win;
   logic [`CGRA_MEM_ADDR_W-1:0] wr_addr;

   logic                        host_hit;
   logic                        host_rd;
   logic                        hit_q;
   logic [`CGRA_DATA_W-1:0]     host_rdata;

   logic                        b_we;
   logic [`CGRA_MEM_ADDR_W-1:0] b_addr;
   logic [`CGRA_DATA_W-1:0]     b_wdata;

   // port A: strided read, offset is k*stride in run cycle k
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         rd_off <= '0;
      end else if (busy) begin
         rd_off <= rd_off + cfg.rd_stride;
      end else begin
         rd_off <= '0;
      end
   end

   assign rd_addr = cfg.rd_start + rd_off;

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         rd_word <= '0;
      end else if (busy) begin
         rd_word <= mem[rd_addr];
      end
   end

   // dataflow write window is idx - wr_delay in 0..N-1
   assign wr_k    = idx - {{(`CGRA_DATA_W-2){1'b0}}, cfg.wr_delay};
   assign wr_win  = busy & cfg.wr_en
                    & (idx >= {{(`CGRA_DATA_W-2){1'b0}}, cfg.wr_delay})
                    & (wr_k < {{(`CGRA_DATA_W-`CGRA_ITER_W){1'b0}}, iter_count});
   assign wr_addr = cfg.wr_start + wr_k[`CGRA_MEM_ADDR_W-1:0];

   // host only gets in while idle
   assign host_hit = host.valid & (host.mem_id == 1'(MEM_ID)) & ~busy;
   assign host_rd  = host_hit & ~host.we;

   // port B mux
   assign b_we    = wr_win | (host_hit & host.we);
   assign b_addr  = busy ? wr_addr : host.addr;
   assign b_wdata = busy ? bus[cfg.wr_sel] : host.wdata;

   always_ff @(posedge rst) begin
      if (b_we) begin
         mem[b_addr] <= b_wdata;
      end
      if (host_rd) begin
         host_rdata <= mem[host.addr];
      end
   end

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         hit_q <= 1'b0;
      end else begin
         hit_q <= host_rd;
      end
   end

   // replace the chain word on our own read
   assign chain_out = hit_q ? host_rdata : chain_in;

endmodule

//--- logic/cgra_alu.sv
// cgra alu
`include "cgra_consts.svh"

module cgra_alu import cgra_pkg::*; (
   input  logic                    rst,
   input  logic                    clk,
   input  alu_cfg_t                cfg,
   input  data_bus_t               bus,
   output logic [`CGRA_DATA_W-1:0] result
);

   logic [`CGRA_DATA_W-1:0] op_a;
   logic [`CGRA_DATA_W-1:0] op_b;
   logic [`CGRA_DATA_W-1:0] alu_d;

   assign op_a = bus[cfg.sel_a];
   assign op_b = bus[cfg.sel_b];

   always_comb begin
      case (cfg.op)
         ALU_ADD:    alu_d = op_a + op_b;
         ALU_SUB:    alu_d = op_a - op_b;
         ALU_AND:    alu_d = op_a & op_b;
         ALU_OR:     alu_d = op_a | op_b;
         ALU_XOR:    alu_d = op_a ^ op_b;
         // unsigned compare
         ALU_MAX:    alu_d = (op_a > op_b) ? op_a : op_b;
         ALU_PASS_A: alu_d = op_a;
         default:    alu_d = '0;
      endcase
   end

   // one cycle through the unit
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         result <= '0;
      end else begin
         result <= alu_d;
      end
   end

endmodule

//--- logic/cgra_mul.sv
// cgra multiplier
`include "cgra_consts.svh"

module cgra_mul import cgra_pkg::*; (
   input  logic                    rst,
   input  logic                    clk,
   input  mul_cfg_t                cfg,
   input  data_bus_t               bus,
   output logic [`CGRA_DATA_W-1:0] result
);

   logic [2*`CGRA_DATA_W-1:0] prod;

   assign prod = bus[cfg.sel_a] * bus[cfg.sel_b];

   // keep the low half only
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         result <= '0;
      end else begin
         result <= prod[`CGRA_DATA_W-1:0];
      end
   end

endmodule

//--- logic/cgra_data_eng.sv
// cgra data engine top
`include "cgra_consts.svh"

module cgra_data_eng import cgra_pkg::*; (
   input  logic                    rst,
   input  logic                    clk,

   // control interface
   input  logic                    ctr_valid,
   input  logic                    ctr_we,
   input  logic                    ctr_addr,
   input  logic [`CGRA_DATA_W-1:0] ctr_data_in,
   output logic [`CGRA_DATA_W-1:0] ctr_data_out,

   // data interface
   input  host_req_t               data_req,
   output logic [`CGRA_DATA_W-1:0] data_data_out,

   // configuration word
   input  eng_cfg_t                config_bus
);

   logic                    busy;
   logic                    start;
   logic                    last;
   eng_cfg_t                cfg;
   logic [`CGRA_DATA_W-1:0] idx;

   data_bus_t               data_bus;
   logic [`CGRA_DATA_W-1:0] mem_rd [`CGRA_N_MEM];
   logic [`CGRA_DATA_W-1:0] alu_res [`CGRA_N_ALU];
   logic [`CGRA_DATA_W-1:0] mul_res;

   // host read chain, mem0 first
   logic [`CGRA_DATA_W-1:0] chain [`CGRA_N_MEM+1];

   cgra_ctrl_fsm u_ctrl (
      .rst          (rst),
      .clk          (clk),
      .ctr_valid    (ctr_valid),
      .ctr_we       (ctr_we),
      .ctr_addr     (ctr_addr),
      .ctr_data_in  (ctr_data_in),
      .ctr_data_out (ctr_data_out),
      .config_bus   (config_bus),
      .last         (last),
      .busy         (busy),
      .start        (start),
      .cfg          (cfg)
   );

   cgra_iter_counter u_iter (
      .rst      (rst),
      .clk      (clk),
      .start    (start),
      .busy     (busy),
      .cfg_iter (cfg.iter_count),
      .idx      (idx),
      .last     (last)
   );

   // bus slots, constants and index tied here
   always_comb begin
      data_bus           = '0;
      data_bus[BUS_ZERO] = '0;
      data_bus[BUS_ONE]  = `CGRA_DATA_W'd1;
      data_bus[BUS_IDX]  = idx;
      for (int m = 0; m < `CGRA_N_MEM; m++) begin
         data_bus[int'(BUS_MEM0) + m] = mem_rd[m];
      end
      for (int a = 0; a < `CGRA_N_ALU; a++) begin
         data_bus[int'(BUS_ALU0) + a] = alu_res[a];
      end
      data_bus[BUS_MUL0] = mul_res;
   end

   assign chain[0] = '0;

   for (genvar m = 0; m < `CGRA_N_MEM; m++) begin : g_mem
      cgra_mem_unit #(
         .MEM_ID (m)
      ) u_mem (
         .rst        (rst),
         .clk        (clk),
         .busy       (busy),
         .idx        (idx),
         .cfg        (cfg.mem[m]),
         .iter_count (cfg.iter_count),
         .bus        (data_bus),
         .host       (data_req),
         .chain_in   (chain[m]),
         .rd_word    (mem_rd[m]),
         .chain_out  (chain[m+1])
      );
   end

   for (genvar a = 0; a < `CGRA_N_ALU; a++) begin : g_alu
      cgra_alu u_alu (
         .rst    (rst),
         .clk    (clk),
         .cfg    (cfg.alu[a]),
         .bus    (data_bus),
         .result (alu_res[a])
      );
   end

   cgra_mul u_mul (
      .rst    (rst),
      .clk    (clk),
      .cfg    (cfg.mul),
      .bus    (data_bus),
      .result (mul_res)
   );

   // end of the chain is the host read port
   assign data_data_out = chain[`CGRA_N_MEM];

endmodule

//--- dv/cgra_checker.sv
// cgra reference checker
`include "cgra_consts.svh"

module cgra_checker import cgra_pkg::*; (
   input  logic                    rst,
   input  logic                    clk,
   input  logic                    ctr_valid,
   input  logic                    ctr_we,
   input  logic                    ctr_addr,
   input  logic [`CGRA_DATA_W-1:0] ctr_data_in,
   input  logic [`CGRA_DATA_W-1:0] ctr_data_out,
   input  host_req_t               data_req,
   input  logic [`CGRA_DATA_W-1:0] data_data_out,
   input  eng_cfg_t                config_bus,
   output int                      errors,
   output int                      checks
);

   logic [`CGRA_DATA_W-1:0] mdl_mem [`CGRA_N_MEM][`CGRA_MEM_DEPTH];
   // current and next bus words, slots follow bus_sel_e
   logic [`CGRA_DATA_W-1:0] slot [`CGRA_BUS_N];
   logic [`CGRA_DATA_W-1:0] nxt [`CGRA_BUS_N];
   logic [`CGRA_DATA_W-1:0] exp_out;
   logic [`CGRA_DATA_W-1:0] exp_ctr;
   eng_cfg_t                m_cfg;
   logic                    m_busy;
   int                      k;

   initial begin
      errors = 0;
      checks = 0;
   end

   function automatic logic [`CGRA_DATA_W-1:0] alu_expect(input alu_op_e op,
         input logic [`CGRA_DATA_W-1:0] a, input logic [`CGRA_DATA_W-1:0] b);
      case (op)
         ALU_ADD:    return a + b;
         ALU_SUB:    return a - b;
         ALU_AND:    return a & b;
         ALU_OR:     return a | b;
         ALU_XOR:    return a ^ b;
         ALU_MAX:    return (a > b) ? a : b;
         ALU_PASS_A: return a;
         default:    return '0;
      endcase
   endfunction

   task automatic compare_word(input logic [`CGRA_DATA_W-1:0] got,
         input logic [`CGRA_DATA_W-1:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("error %0t: %s got %h, expected %h", $time, what, got, exp);
      end
   endtask

   always @(posedge rst or posedge clk) begin
      if (clk) begin
         m_busy  = 1'b0;
         m_cfg   = '0;
         k       = 0;
         exp_out = '0;
         for (int s = 0; s < `CGRA_BUS_N; s++) slot[s] = '0;
      end else begin
         // outputs of the cycle that ends at this edge
         compare_word(data_data_out, exp_out, "host read data");
         exp_ctr = (ctr_valid && !ctr_we && ctr_addr) ? 16'(!m_busy) : '0;
         compare_word(ctr_data_out, exp_ctr, "control read data");

         slot[BUS_ZERO] = '0;
         slot[BUS_ONE]  = 16'd1;
         slot[BUS_IDX]  = 16'(k);
         nxt = slot;
         nxt[BUS_ALU0] = alu_expect(m_cfg.alu[0].op, slot[m_cfg.alu[0].sel_a],
                                    slot[m_cfg.alu[0].sel_b]);
         nxt[BUS_ALU1] = alu_expect(m_cfg.alu[1].op, slot[m_cfg.alu[1].sel_a],
                                    slot[m_cfg.alu[1].sel_b]);
         nxt[BUS_MUL0] = 16'(slot[m_cfg.mul.sel_a] * slot[m_cfg.mul.sel_b]);

         // host side only while idle
         exp_out = '0;
         if (data_req.valid && !m_busy) begin
            if (data_req.we) mdl_mem[data_req.mem_id][data_req.addr] = data_req.wdata;
            else exp_out = mdl_mem[data_req.mem_id][data_req.addr];
         end

         if (m_busy) begin
            // strided reads see memory before this edge's writes
            for (int m = 0; m < `CGRA_N_MEM; m++) begin
               nxt[3'(int'(BUS_MEM0) + m)] = mdl_mem[1'(m)][6'(int'(m_cfg.mem[m].rd_start)
                                             + k * int'(m_cfg.mem[m].rd_stride))];
            end
            for (int m = 0; m < `CGRA_N_MEM; m++) begin
               if (m_cfg.mem[m].wr_en && k >= int'(m_cfg.mem[m].wr_delay)
                   && k - int'(m_cfg.mem[m].wr_delay) < int'(m_cfg.iter_count)) begin
                  mdl_mem[1'(m)][6'(int'(m_cfg.mem[m].wr_start) + k
                                    - int'(m_cfg.mem[m].wr_delay))] = slot[m_cfg.mem[m].wr_sel];
               end
            end
            if (k == int'(m_cfg.iter_count) + `CGRA_DRAIN - 1) m_busy = 1'b0;
            k++;
         end else if (ctr_valid && ctr_we && !ctr_addr && ctr_data_in[0]) begin
            m_cfg  = config_bus;
            m_busy = 1'b1;
            k      = 0;
         end
         slot = nxt;
      end
   end

endmodule

//--- dv/tb_cgra.sv
// cgra engine testbench
`include "cgra_consts.svh"

module tb_cgra import cgra_pkg::*; ();

   // longest run, plus load, read back and poll cycles
   localparam int RUN_MAX     = (1 << `CGRA_ITER_W) + `CGRA_DRAIN + 4;
   localparam int N_ACCESS    = 4 * 4 * `CGRA_MEM_DEPTH + 200;
   localparam int CYCLE_LIMIT = 2 * (4 * RUN_MAX + N_ACCESS);

   logic                    rst = 1'b0;
   logic                    clk;
   logic                    ctr_valid;
   logic                    ctr_we;
   logic                    ctr_addr;
   logic [`CGRA_DATA_W-1:0] ctr_data_in;
   logic [`CGRA_DATA_W-1:0] ctr_data_out;
   host_req_t               data_req;
   logic [`CGRA_DATA_W-1:0] data_data_out;
   eng_cfg_t                config_bus;
   int                      errors;
   int                      checks;
   int                      tb_errs = 0;
   int                      err_mark = 0;
   int                      n_tests = 0;
   int                      n_failed = 0;
   int                      cycles = 0;

   cgra_data_eng u_dut (.*);

   cgra_checker cgra_checker (.*);

   // rst is the clock
   always #4 rst = ~rst;

   always @(posedge rst) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("run did not finish in time");
         $display("STATUS: FAIL");
         $finish;
      end
   end

   task automatic drive_idle();
      ctr_valid   = 1'b0;
      ctr_we      = 1'b0;
      ctr_addr    = 1'b0;
      ctr_data_in = '0;
      data_req    = '0;
   endtask

   task automatic host_access(input logic we, input logic id, input logic [5:0] addr,
         input logic [`CGRA_DATA_W-1:0] wdata);
      @(negedge rst);
      drive_idle();
      data_req.valid  = 1'b1;
      data_req.we     = we;
      data_req.mem_id = id;
      data_req.addr   = addr;
      data_req.wdata  = wdata;
   endtask

   task automatic ctrl_access(input logic we, input logic addr, input logic [15:0] din);
      @(negedge rst);
      drive_idle();
      ctr_valid   = 1'b1;
      ctr_we      = we;
      ctr_addr    = addr;
      ctr_data_in = din;
   endtask

   task automatic quiet(input int n);
      repeat (n) begin
         @(negedge rst);
         drive_idle();
      end
   endtask

   task automatic load_mems();
      for (int m = 0; m < `CGRA_N_MEM; m++)
         for (int a = 0; a < `CGRA_MEM_DEPTH; a++) host_access(1'b1, 1'(m), 6'(a), 16'($urandom));
   endtask

   task automatic read_back();
      for (int m = 0; m < `CGRA_N_MEM; m++)
         for (int a = 0; a < `CGRA_MEM_DEPTH; a++) host_access(1'b0, 1'(m), 6'(a), '0);
   endtask

   // strobe, then poll status until idle
   task automatic run_engine(input eng_cfg_t c, input bit restrobe, input bit noise);
      logic [95:0] junk;
      int          j;
      bit          done;
      config_bus = c;
      ctrl_access(1'b1, 1'b0, 16'h0001);
      j    = 0;
      done = 1'b0;
      while (!done) begin
         @(negedge rst);
         drive_idle();
         if (j == 1) begin
            junk       = {$urandom, $urandom, $urandom};
            config_bus = junk[$bits(eng_cfg_t)-1:0];
         end
         ctr_valid = 1'b1;
         if (restrobe && j == 2) begin
            ctr_we      = 1'b1;
            ctr_data_in = 16'h0001;
         end else begin
            ctr_addr = 1'b1;
         end
         if (noise) begin
            data_req.valid  = 1'b1;
            data_req.we     = 1'b1;
            data_req.mem_id = 1'($urandom);
            data_req.addr   = 6'($urandom);
            data_req.wdata  = 16'($urandom);
         end
         @(posedge rst);
         if (ctr_addr && ctr_data_out[0]) done = 1'b1;
         else j++;
      end
      if (j != int'(c.iter_count) + `CGRA_DRAIN) begin
         tb_errs++;
         $display("error %0t: idle after %0d cycles, expected %0d", $time, j,
                  int'(c.iter_count) + `CGRA_DRAIN);
      end
   endtask

   function automatic eng_cfg_t alu_path_cfg();
      eng_cfg_t c;
      c = '0;
      c.iter_count        = 6'(8 + $urandom % 56);
      c.mem[0].rd_start   = 6'($urandom);
      c.mem[0].rd_stride  = 6'd1;
      c.mem[1].rd_start   = 6'($urandom);
      c.mem[1].rd_stride  = 6'($urandom);
      c.mem[1].wr_en      = 1'b1;
      c.mem[1].wr_start   = 6'($urandom);
      c.mem[1].wr_sel     = BUS_ALU0;
      c.mem[1].wr_delay   = 2'd2;
      c.alu[0].op         = alu_op_e'(3'($urandom % 7));
      c.alu[0].sel_a      = BUS_MEM0;
      c.alu[0].sel_b      = ($urandom % 2 == 1) ? BUS_MEM1 : BUS_IDX;
      return c;
   endfunction

   // mem0 into the multiplier, then alu1, written back with delay 3
   function automatic eng_cfg_t mul_path_cfg();
      eng_cfg_t c;
      c = '0;
      c.iter_count        = 6'(8 + $urandom % 56);
      c.mem[0].rd_start   = 6'($urandom);
      c.mem[0].rd_stride  = 6'($urandom);
      c.mem[1].rd_stride  = 6'd1;
      c.mem[1].wr_en      = 1'b1;
      c.mem[1].wr_start   = 6'($urandom);
      c.mem[1].wr_sel     = BUS_ALU1;
      c.mem[1].wr_delay   = 2'd3;
      c.mul.sel_a         = BUS_MEM0;
      c.mul.sel_b         = ($urandom % 2 == 1) ? BUS_MEM0 : BUS_IDX;
      c.alu[1].op         = alu_op_e'(3'($urandom % 7));
      c.alu[1].sel_a      = BUS_MUL0;
      c.alu[1].sel_b      = ($urandom % 2 == 1) ? BUS_ONE : BUS_IDX;
      return c;
   endfunction

   task automatic report_test(input string name);
      int total;
      quiet(2);
      total = errors + tb_errs;
      n_tests++;
      if (total == err_mark) begin
         $display("test %0d %s: ok", n_tests, name);
      end else begin
         n_failed++;
         $display("test %0d %s: %0d errors", n_tests, name, total - err_mark);
      end
      err_mark = total;
   endtask

   initial begin
      logic [6:0] spots[$];
      void'($urandom(32'hc606_cc1b));
      clk        = 1'b1;
      config_bus = '0;
      drive_idle();
      repeat (8) @(posedge rst);
      @(negedge rst);
      clk = 1'b0;

      ctrl_access(1'b0, 1'b1, '0);
      ctrl_access(1'b0, 1'b0, '0);
      report_test("reset state");

      repeat (40) spots.push_back(7'($urandom));
      foreach (spots[i]) host_access(1'b1, spots[i][6], spots[i][5:0], 16'($urandom));
      foreach (spots[i]) host_access(1'b0, spots[i][6], spots[i][5:0], '0);
      report_test("host write and read");

      load_mems();
      run_engine(alu_path_cfg(), 1'b0, 1'b0);
      read_back();
      report_test("alu0 dataflow");

      load_mems();
      run_engine(mul_path_cfg(), 1'b0, 1'b0);
      read_back();
      report_test("mul to alu1 chain");

      load_mems();
      run_engine(alu_path_cfg(), 1'b1, 1'b0);
      read_back();
      report_test("status timing and repeated strobe");

      load_mems();
      run_engine(mul_path_cfg(), 1'b0, 1'b1);
      read_back();
      report_test("host writes during run");

      $display("tests %0d, failed %0d, checks %0d, errors %0d", n_tests, n_failed, checks,
               errors + tb_errs);
      if (errors + tb_errs == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

//--- sim.f
+incdir+logic
logic/cgra_pkg.sv
logic/cgra_ctrl_fsm.sv
logic/cgra_iter_counter.sv
logic/cgra_mem_unit.sv
logic/cgra_alu.sv
logic/cgra_mul.sv
logic/cgra_data_eng.sv
dv/cgra_checker.sv
dv/tb_cgra.sv

//--- Makefile
SIM       := verilator
SIMFLAGS  := --binary --timing
LINTFLAGS := --lint-only -Wall --timing
TOP       := tb_cgra
FILELIST  := sim.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@grep -q "STATUS: PASS" $(LOG)

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
